//--- source/spdr_pkg.sv
package spdr_pkg;

    localparam int MEM_WORDS = 256;
    localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);

    localparam logic [7:0] CHAR_CR = 8'h0D;
    localparam logic [7:0] CHAR_LF = 8'h0A;

    localparam logic [2:0] RESET_SIZE = 3'd4;

    typedef logic [7:0] byte_t;
    typedef logic [3:0] nibble_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] lane_mask_t;
    typedef logic [2:0] size_t;
    typedef logic [3:0] digit_count_t;

    typedef enum logic [2:0] {
        OP_SET_ADDR,
        OP_SET_SIZE,
        OP_WRITE,
        OP_READ,
        OP_WRITE_GPO,
        OP_READ_GPI,
        OP_SHOW_ADDR
    } cmd_op_e;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_NUMBER,
        DEC_SIZE
    } decode_state_e;

    typedef enum logic [1:0] {
        EXE_IDLE,
        EXE_WRITE_WAIT,
        EXE_READ_WAIT
    } execute_state_e;

    typedef enum logic [1:0] {
        RPL_IDLE,
        RPL_DIGITS,
        RPL_CR,
        RPL_LF
    } reply_state_e;

    typedef struct packed {
        cmd_op_e op;
        word_t value;
        byte_t size_char;
    } cmd_t;

    typedef struct packed {
        logic wr;
        lane_mask_t mask;
        word_t addr;
        word_t wdata;
    } bus_req_t;

    typedef struct packed {
        word_t rdata;
    } bus_rsp_t;

    // Zero digits sends only CR LF
    typedef struct packed {
        word_t data;
        digit_count_t digits;
    } reply_t;

endpackage

//--- source/spdr_cmd_decode.sv
`timescale 1ns/10ps

module spdr_cmd_decode
(
    input  logic            clk,
    input  logic            rst,
    input  logic            rx_valid,
    input  spdr_pkg::byte_t rx_byte,
    output logic            cmd_valid,
    output spdr_pkg::cmd_t  cmd,
    output logic            echo_valid,
    output spdr_pkg::byte_t echo_byte
);

    spdr_pkg::decode_state_e state;
    spdr_pkg::decode_state_e next_state;
    spdr_pkg::cmd_op_e pend_op;
    spdr_pkg::cmd_op_e next_op;
    spdr_pkg::word_t acc;
    spdr_pkg::nibble_t rx_nibble;
    logic rx_is_hex;
    logic do_echo;
    logic do_issue;

    // Hex digit in either case
    always_comb
    begin
        rx_is_hex = 1'b1;
        rx_nibble = '0;
        if (rx_byte >= "0" && rx_byte <= "9")
            rx_nibble = spdr_pkg::nibble_t'(rx_byte - "0");
        else if (rx_byte >= "A" && rx_byte <= "F")
            rx_nibble = spdr_pkg::nibble_t'(rx_byte - "A" + 8'd10);
        else if (rx_byte >= "a" && rx_byte <= "f")
            rx_nibble = spdr_pkg::nibble_t'(rx_byte - "a" + 8'd10);
        else
            rx_is_hex = 1'b0;
    end

    always_comb
    begin
        next_state = state;
        next_op = pend_op;
        do_echo = 1'b0;
        do_issue = 1'b0;
        if (rx_valid)
        begin
            case (state)
                spdr_pkg::DEC_IDLE:
                begin
                    do_echo = 1'b1;
                    case (rx_byte)
                        "@":
                        begin
                            next_op = spdr_pkg::OP_SET_ADDR;
                            next_state = spdr_pkg::DEC_NUMBER;
                        end
                        "#":
                        begin
                            next_op = spdr_pkg::OP_SET_SIZE;
                            next_state = spdr_pkg::DEC_SIZE;
                        end
                        "=":
                        begin
                            next_op = spdr_pkg::OP_WRITE;
                            next_state = spdr_pkg::DEC_NUMBER;
                        end
                        "%":
                        begin
                            next_op = spdr_pkg::OP_WRITE_GPO;
                            next_state = spdr_pkg::DEC_NUMBER;
                        end
                        "?":
                        begin
                            next_op = spdr_pkg::OP_READ;
                            do_issue = 1'b1;
                        end
                        "/":
                        begin
                            next_op = spdr_pkg::OP_READ_GPI;
                            do_issue = 1'b1;
                        end
                        "!":
                        begin
                            next_op = spdr_pkg::OP_SHOW_ADDR;
                            do_issue = 1'b1;
                        end
                        default:
                            do_echo = 1'b0;
                    endcase
                end
                spdr_pkg::DEC_NUMBER:
                begin
                    // First non-hex ends the number and is swallowed
                    if (rx_is_hex)
                        do_echo = 1'b1;
                    else
                    begin
                        do_issue = 1'b1;
                        next_state = spdr_pkg::DEC_IDLE;
                    end
                end
                spdr_pkg::DEC_SIZE:
                begin
                    do_echo = 1'b1;
                    do_issue = 1'b1;
                    next_state = spdr_pkg::DEC_IDLE;
                end
                default:
                    next_state = spdr_pkg::DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= spdr_pkg::DEC_IDLE;
            pend_op <= spdr_pkg::OP_SET_ADDR;
            cmd_valid <= 1'b0;
            echo_valid <= 1'b0;
        end
        else
        begin
            state <= next_state;
            pend_op <= next_op;
            cmd_valid <= do_issue;
            echo_valid <= do_echo;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_issue)
        begin
            cmd.op <= next_op;
            cmd.value <= acc;
            cmd.size_char <= rx_byte;
        end
        if (do_echo)
            echo_byte <= rx_byte;
        // Only the last eight digits survive
        if (rx_valid)
        begin
            if (rx_is_hex)
                acc <= {acc[27:0], rx_nibble};
            else if (state == spdr_pkg::DEC_IDLE)
                acc <= '0;
        end
    end

endmodule

//--- source/spdr_bus_execute.sv
`timescale 1ns/10ps

module spdr_bus_execute
(
    input  logic               clk,
    input  logic               rst,
    input  logic               cmd_valid,
    input  spdr_pkg::cmd_t     cmd,
    input  spdr_pkg::word_t    gpi,
    output spdr_pkg::word_t    gpo,
    output logic               gpo_strobe,
    output logic               gpi_strobe,
    output logic               req_valid,
    output spdr_pkg::bus_req_t req,
    input  logic               rsp_valid,
    input  spdr_pkg::bus_rsp_t rsp,
    output logic               reply_valid,
    output spdr_pkg::reply_t   reply
);

    spdr_pkg::execute_state_e state;
    spdr_pkg::word_t addr;
    spdr_pkg::size_t size;
    spdr_pkg::size_t size_sel;
    spdr_pkg::lane_mask_t lane_mask;
    spdr_pkg::word_t wdata_lanes;
    spdr_pkg::word_t rdata_lane;
    spdr_pkg::digit_count_t read_digits;
    logic accept;

    assign accept = cmd_valid && (state == spdr_pkg::EXE_IDLE);

    always_comb
    begin
        case (cmd.size_char)
            "b": size_sel = 3'd1;
            "h": size_sel = 3'd2;
            "w": size_sel = 3'd4;
            default: size_sel = 3'd0;
        endcase
    end

    // Lane steering from size and low address bits
    always_comb
    begin
        case (size)
            3'd1:
            begin
                lane_mask = 4'b0001 << addr[1:0];
                wdata_lanes = {4{cmd.value[7:0]}};
                rdata_lane = {24'd0, rsp.rdata[{addr[1:0], 3'b000} +: 8]};
                read_digits = 4'd2;
            end
            3'd2:
            begin
                lane_mask = addr[1] ? 4'b1100 : 4'b0011;
                wdata_lanes = {2{cmd.value[15:0]}};
                rdata_lane = {16'd0, rsp.rdata[{addr[1], 4'b0000} +: 16]};
                read_digits = 4'd4;
            end
            3'd4:
            begin
                lane_mask = 4'b1111;
                wdata_lanes = cmd.value;
                rdata_lane = rsp.rdata;
                read_digits = 4'd8;
            end
            default:
            begin
                // Size 0 accesses the whole word but shows the low byte
                lane_mask = 4'b1111;
                wdata_lanes = cmd.value;
                rdata_lane = rsp.rdata;
                read_digits = 4'd2;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= spdr_pkg::EXE_IDLE;
            addr <= '0;
            size <= spdr_pkg::RESET_SIZE;
            gpo <= '0;
            gpo_strobe <= 1'b0;
            gpi_strobe <= 1'b0;
            req_valid <= 1'b0;
            reply_valid <= 1'b0;
        end
        else
        begin
            gpo_strobe <= 1'b0;
            gpi_strobe <= 1'b0;
            req_valid <= 1'b0;
            reply_valid <= 1'b0;
            case (state)
                spdr_pkg::EXE_IDLE:
                begin
                    if (cmd_valid)
                    begin
                        case (cmd.op)
                            spdr_pkg::OP_SET_ADDR:
                                addr <= cmd.value;
                            spdr_pkg::OP_SET_SIZE:
                                size <= size_sel;
                            spdr_pkg::OP_WRITE:
                                state <= spdr_pkg::EXE_WRITE_WAIT;
                            spdr_pkg::OP_READ:
                                state <= spdr_pkg::EXE_READ_WAIT;
                            spdr_pkg::OP_WRITE_GPO:
                            begin
                                gpo <= cmd.value;
                                gpo_strobe <= 1'b1;
                            end
                            spdr_pkg::OP_READ_GPI:
                                gpi_strobe <= 1'b1;
                            default:
                                state <= spdr_pkg::EXE_IDLE;
                        endcase
                        if (cmd.op == spdr_pkg::OP_WRITE || cmd.op == spdr_pkg::OP_READ)
                            req_valid <= 1'b1;
                        else
                            reply_valid <= 1'b1;
                    end
                end
                spdr_pkg::EXE_WRITE_WAIT, spdr_pkg::EXE_READ_WAIT:
                begin
                    if (rsp_valid)
                    begin
                        addr <= addr + spdr_pkg::word_t'(size);
                        reply_valid <= 1'b1;
                        state <= spdr_pkg::EXE_IDLE;
                    end
                end
                default:
                    state <= spdr_pkg::EXE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req.wr <= (cmd.op == spdr_pkg::OP_WRITE);
            req.mask <= lane_mask;
            req.addr <= addr;
            req.wdata <= wdata_lanes;
            reply.data <= (cmd.op == spdr_pkg::OP_READ_GPI) ? gpi : addr;
            if (cmd.op == spdr_pkg::OP_READ_GPI || cmd.op == spdr_pkg::OP_SHOW_ADDR)
                reply.digits <= 4'd8;
            else
                reply.digits <= 4'd0;
        end
        else if (state == spdr_pkg::EXE_READ_WAIT && rsp_valid)
        begin
            reply.data <= rdata_lane;
            reply.digits <= read_digits;
        end
    end

endmodule

//--- source/spdr_reply_format.sv
`timescale 1ns/10ps

module spdr_reply_format
(
    input  logic             clk,
    input  logic             rst,
    input  logic             echo_valid,
    input  spdr_pkg::byte_t  echo_byte,
    input  logic             reply_valid,
    input  spdr_pkg::reply_t reply,
    output logic             tx_valid,
    output spdr_pkg::byte_t  tx_byte
);

    spdr_pkg::reply_state_e state;
    spdr_pkg::word_t shift;
    spdr_pkg::digit_count_t count;
    logic [5:0] align_bits;
    spdr_pkg::byte_t digit_char;
    logic tx_next_valid;
    spdr_pkg::byte_t tx_next_byte;

    // Left-justify so the first digit sits in the top nibble
    assign align_bits = {4'd8 - reply.digits, 2'b00};

    always_comb
    begin
        if (shift[31:28] < 4'd10)
            digit_char = "0" + {4'd0, shift[31:28]};
        else
            digit_char = "A" + {4'd0, shift[31:28]} - 8'd10;
    end

    always_comb
    begin
        case (state)
            spdr_pkg::RPL_DIGITS:
            begin
                tx_next_valid = 1'b1;
                tx_next_byte = digit_char;
            end
            spdr_pkg::RPL_CR:
            begin
                tx_next_valid = 1'b1;
                tx_next_byte = spdr_pkg::CHAR_CR;
            end
            spdr_pkg::RPL_LF:
            begin
                tx_next_valid = 1'b1;
                tx_next_byte = spdr_pkg::CHAR_LF;
            end
            default:
            begin
                tx_next_valid = echo_valid;
                tx_next_byte = echo_byte;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= spdr_pkg::RPL_IDLE;
            count <= '0;
            tx_valid <= 1'b0;
        end
        else
        begin
            tx_valid <= tx_next_valid;
            case (state)
                spdr_pkg::RPL_IDLE:
                begin
                    if (reply_valid)
                    begin
                        count <= reply.digits;
                        if (reply.digits == '0)
                            state <= spdr_pkg::RPL_CR;
                        else
                            state <= spdr_pkg::RPL_DIGITS;
                    end
                end
                spdr_pkg::RPL_DIGITS:
                begin
                    count <= count - 4'd1;
                    if (count == 4'd1)
                        state <= spdr_pkg::RPL_CR;
                end
                spdr_pkg::RPL_CR:
                    state <= spdr_pkg::RPL_LF;
                default:
                    state <= spdr_pkg::RPL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        tx_byte <= tx_next_byte;
        if (state == spdr_pkg::RPL_IDLE && reply_valid)
            shift <= reply.data << align_bits;
        else if (state == spdr_pkg::RPL_DIGITS)
            shift <= {shift[27:0], 4'd0};
    end

endmodule

//--- source/spdr_sram_target.sv
`timescale 1ns/10ps

module spdr_sram_target
(
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  spdr_pkg::bus_req_t req,
    output logic               rsp_valid,
    output spdr_pkg::bus_rsp_t rsp
);

    spdr_pkg::word_t mem [spdr_pkg::MEM_WORDS];
    logic [spdr_pkg::MEM_ADDR_BITS-1:0] index;

    // Upper address bits wrap onto the array
    assign index = req.addr[spdr_pkg::MEM_ADDR_BITS+1:2];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= req_valid;
    end

    // A write still returns the word as it was before the write
    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            rsp.rdata <= mem[index];
            if (req.wr)
            begin
                for (int lane = 0; lane < 4; lane++)
                begin
                    if (req.mask[lane])
                        mem[index][lane*8 +: 8] <= req.wdata[lane*8 +: 8];
                end
            end
        end
    end

endmodule

//--- source/spdr_top.sv
`timescale 1ns/10ps

module spdr_top
(
    input  logic            clk,
    input  logic            rst,
    input  logic            rx_valid,
    input  spdr_pkg::byte_t rx_byte,
    output logic            tx_valid,
    output spdr_pkg::byte_t tx_byte,
    input  spdr_pkg::word_t gpi,
    output spdr_pkg::word_t gpo,
    output logic            gpo_strobe,
    output logic            gpi_strobe
);

    logic cmd_valid;
    spdr_pkg::cmd_t cmd;
    logic echo_valid;
    spdr_pkg::byte_t echo_byte;
    logic req_valid;
    spdr_pkg::bus_req_t req;
    logic rsp_valid;
    spdr_pkg::bus_rsp_t rsp;
    logic reply_valid;
    spdr_pkg::reply_t reply;

    spdr_cmd_decode u_decode
    (
        .clk(clk),
        .rst(rst),
        .rx_valid(rx_valid),
        .rx_byte(rx_byte),
        .cmd_valid(cmd_valid),
        .cmd(cmd),
        .echo_valid(echo_valid),
        .echo_byte(echo_byte)
    );

    spdr_bus_execute u_execute
    (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd(cmd),
        .gpi(gpi),
        .gpo(gpo),
        .gpo_strobe(gpo_strobe),
        .gpi_strobe(gpi_strobe),
        .req_valid(req_valid),
        .req(req),
        .rsp_valid(rsp_valid),
        .rsp(rsp),
        .reply_valid(reply_valid),
        .reply(reply)
    );

    spdr_reply_format u_result
    (
        .clk(clk),
        .rst(rst),
        .echo_valid(echo_valid),
        .echo_byte(echo_byte),
        .reply_valid(reply_valid),
        .reply(reply),
        .tx_valid(tx_valid),
        .tx_byte(tx_byte)
    );

    spdr_sram_target u_memory
    (
        .clk(clk),
        .rst(rst),
        .req_valid(req_valid),
        .req(req),
        .rsp_valid(rsp_valid),
        .rsp(rsp)
    );

endmodule

//--- testbench/spdr_ref_model.svh
// Monitor state as the host sees it
logic [31:0] ref_addr;
logic [2:0] ref_size;
logic [31:0] ref_gpo;
logic [31:0] ref_acc;
logic [31:0] ref_mem [spdr_pkg::MEM_WORDS];
logic [7:0] ref_cmd;
bit ref_in_number;
bit ref_in_size;

function automatic void reset_model();
    ref_addr = '0;
    ref_size = 3'd4;
    ref_gpo = '0;
    ref_acc = '0;
    ref_cmd = "@";
    ref_in_number = 1'b0;
    ref_in_size = 1'b0;
endfunction

function automatic bit is_hex(input logic [7:0] c);
    return (c >= "0" && c <= "9") || (c >= "A" && c <= "F") || (c >= "a" && c <= "f");
endfunction

function automatic logic [3:0] hex_value(input logic [7:0] c);
    if (c <= "9")
        return 4'(c - "0");
    else if (c <= "F")
        return 4'(c - "A" + 8'd10);
    return 4'(c - "a" + 8'd10);
endfunction

// Upper-case digits from the lowest nibbles of the value
function automatic string hex_text(input logic [31:0] value, input int digits);
    string text;
    logic [3:0] nib;
    text = "";
    for (int i = digits - 1; i >= 0; i--)
    begin
        nib = value[i*4 +: 4];
        if (nib < 4'd10)
            text = {text, $sformatf("%c", 8'h30 + nib)};
        else
            text = {text, $sformatf("%c", 8'h37 + nib)};
    end
    return text;
endfunction

function automatic string crlf();
    return $sformatf("%c%c", 8'h0D, 8'h0A);
endfunction

function automatic int ref_index();
    return int'((ref_addr >> 2) % spdr_pkg::MEM_WORDS);
endfunction

function automatic void model_write(input logic [31:0] value);
    int idx;
    idx = ref_index();
    case (ref_size)
        3'd1:
            ref_mem[idx][ref_addr[1:0]*8 +: 8] = value[7:0];
        3'd2:
            ref_mem[idx][ref_addr[1]*16 +: 16] = value[15:0];
        default:
            ref_mem[idx] = value;
    endcase
    ref_addr = ref_addr + ref_size;
endfunction

function automatic string model_read();
    logic [31:0] word;
    string text;
    word = ref_mem[ref_index()];
    case (ref_size)
        3'd1:
            text = hex_text(word >> (ref_addr[1:0] * 8), 2);
        3'd2:
            text = hex_text(word >> (ref_addr[1] * 16), 4);
        3'd4:
            text = hex_text(word, 8);
        default:
            text = hex_text(word, 2);
    endcase
    ref_addr = ref_addr + ref_size;
    return text;
endfunction

// Everything the monitor should transmit in answer to one character
function automatic string model_char(input logic [7:0] c, input logic [31:0] gpi_now);
    string out;
    out = "";
    if (ref_in_size)
    begin
        ref_in_size = 1'b0;
        case (c)
            "b": ref_size = 3'd1;
            "h": ref_size = 3'd2;
            "w": ref_size = 3'd4;
            default: ref_size = 3'd0;
        endcase
        out = {$sformatf("%c", c), crlf()};
    end
    else if (ref_in_number)
    begin
        if (is_hex(c))
        begin
            ref_acc = {ref_acc[27:0], hex_value(c)};
            out = $sformatf("%c", c);
        end
        else
        begin
            // Terminator is swallowed
            ref_in_number = 1'b0;
            if (ref_cmd == "@")
                ref_addr = ref_acc;
            else if (ref_cmd == "=")
                model_write(ref_acc);
            else
                ref_gpo = ref_acc;
            out = crlf();
        end
    end
    else
    begin
        case (c)
            "@", "=", "%":
            begin
                ref_cmd = c;
                ref_acc = '0;
                ref_in_number = 1'b1;
                out = $sformatf("%c", c);
            end
            "#":
            begin
                ref_in_size = 1'b1;
                out = "#";
            end
            "?": out = {"?", model_read(), crlf()};
            "/": out = {"/", hex_text(gpi_now, 8), crlf()};
            "!": out = {"!", hex_text(ref_addr, 8), crlf()};
            default: out = "";
        endcase
    end
    return out;
endfunction

//--- testbench/spdr_tb.sv
`timescale 1ns/10ps

module spdr_tb;

    logic clk;
    logic rst;
    logic rx_valid;
    spdr_pkg::byte_t rx_byte;
    logic tx_valid;
    spdr_pkg::byte_t tx_byte;
    spdr_pkg::word_t gpi;
    spdr_pkg::word_t gpo;
    logic gpo_strobe;
    logic gpi_strobe;

    integer seed;
    string exp_text;
    logic [7:0] expected_byte;
    int got_count;
    int errors;
    int test_start_errors;
    int tests_run;
    int tests_failed;
    int chars_sent;
    int gpo_pulses;
    int gpi_pulses;
    int cycles;

    `include "spdr_ref_model.svh"

    spdr_top dut
    (
        .clk(clk),
        .rst(rst),
        .rx_valid(rx_valid),
        .rx_byte(rx_byte),
        .tx_valid(tx_valid),
        .tx_byte(tx_byte),
        .gpi(gpi),
        .gpo(gpo),
        .gpo_strobe(gpo_strobe),
        .gpi_strobe(gpi_strobe)
    );

    initial
        clk = 1'b0;

    always #10 clk = ~clk;

    // Transmit bytes are checked in order against the expected stream
    always @(negedge clk)
    begin
        if (tx_valid)
        begin
            assert (got_count < exp_text.len())
            else
            begin
                $display("Extra transmit byte %h arrived with nothing expected", tx_byte);
                errors++;
            end
            if (got_count < exp_text.len())
            begin
                expected_byte = exp_text[got_count];
                assert (tx_byte == expected_byte)
                else
                begin
                    $display("** Error tx_byte[%0d]: got %h expected %h",
                             got_count, tx_byte, expected_byte);
                    errors++;
                end
            end
            got_count++;
        end
        if (gpo_strobe)
            gpo_pulses++;
        if (gpi_strobe)
            gpi_pulses++;
    end

    // Budget grows with every character sent
    initial
    begin
        cycles = 0;
        while (cycles <= chars_sent * 40 + 200)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    task automatic send_char(input logic [7:0] c);
        string expected;
        int target;
        expected = model_char(c, gpi);
        exp_text = {exp_text, expected};
        target = exp_text.len();
        chars_sent++;
        @(posedge clk);
        rx_valid <= 1'b1;
        rx_byte <= c;
        @(posedge clk);
        rx_valid <= 1'b0;
        // Echo would appear two cycles after the strobe
        if (expected.len() == 0)
            repeat (4) @(posedge clk);
        else
        begin
            while (got_count < target)
                @(posedge clk);
        end
    endtask

    task automatic send_text(input string text);
        for (int i = 0; i < text.len(); i++)
            send_char(text[i]);
    endtask

    task automatic set_gpi(input logic [31:0] value);
        @(posedge clk);
        gpi <= value;
        @(posedge clk);
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp)
        else
        begin
            $display("** Error %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        assert (got_count == exp_text.len())
        else
        begin
            $display("%s: %0d transmit bytes arrived but %0d were expected",
                     name, got_count, exp_text.len());
            errors++;
        end
        tests_run++;
        if (errors == test_start_errors)
            $display("Test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_start_errors);
        end
    endtask

    task automatic test_reset_state();
        begin_test();
        check_word("gpo", gpo, 32'h0);
        send_text("!");
        send_text("=5a0f3c96.@0.?");
        end_test("reset state");
    endtask

    task automatic test_word_access();
        logic [31:0] base;
        begin_test();
        for (int i = 0; i < 4; i++)
        begin
            base = random_word() & 32'hFFFF_FFFC;
            send_text($sformatf("@%h.=%h.", base, random_word()));
            send_text($sformatf("=%h.@%h.", random_word(), base));
            send_text("??!");
        end
        end_test("word access");
    endtask

    task automatic test_narrow_access();
        logic [31:0] base;
        begin_test();
        base = random_word() & 32'h0000_03F0;
        send_text($sformatf("#w@%h.=%h.=%h.", base, random_word(), random_word()));
        send_text($sformatf("#b@%h.=%h.?!", base + 1, random_word()));
        send_text($sformatf("#h@%h.=%h.", base + 2, random_word()));
        send_text($sformatf("@%h.??!", base));
        send_text($sformatf("#b@%h.????", base));
        // Size 0 writes the whole word and leaves the address in place
        send_text($sformatf("#x@%h.=deadbeef.??!", base + 4));
        send_text($sformatf("#w@%h.??", base));
        end_test("byte and half-word access");
    endtask

    task automatic test_gpio();
        int pulses;
        begin_test();
        pulses = gpo_pulses;
        send_text($sformatf("%%%h.", random_word()));
        check_word("gpo", gpo, ref_gpo);
        check_word("gpo_strobe pulses", gpo_pulses - pulses, 1);
        set_gpi(random_word());
        pulses = gpi_pulses;
        send_text("/");
        check_word("gpi_strobe pulses", gpi_pulses - pulses, 1);
        end_test("gpio");
    endtask

    task automatic test_parsing();
        begin_test();
        send_text("xyz5 QZ+");
        send_text("%123456789abcdef0.");
        check_word("gpo", gpo, ref_gpo);
        send_text("@ABCdef12 !");
        // A command character can end a number without running
        send_text("@0000001C?!");
        send_text("#b#W");
        end_test("parsing");
    endtask

    initial
    begin
        seed = 32'h3fc1e5cf;
        rst = 1'b1;
        rx_valid = 1'b0;
        rx_byte = '0;
        gpi = '0;
        exp_text = "";
        got_count = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        chars_sent = 0;
        gpo_pulses = 0;
        gpi_pulses = 0;
        reset_model();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset_state();
        test_word_access();
        test_narrow_access();
        test_gpio();
        test_parsing();
        $display("Tests run %0d, failed %0d, errors %0d, characters sent %0d",
                 tests_run, tests_failed, errors, chars_sent);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- files.f
+incdir+testbench
source/spdr_pkg.sv
source/spdr_cmd_decode.sv
source/spdr_bus_execute.sv
source/spdr_reply_format.sv
source/spdr_sram_target.sv
source/spdr_top.sv
testbench/spdr_tb.sv
